// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --timing --assert
TOP        ?= ramcfg_tb
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
hdl/ramcfg_pkg.sv
hdl/delay_pipe.sv
hdl/ramcfg_mem.sv
hdl/ramcfg_access.sv
hdl/ramcfg_alarm.sv
hdl/ramcfg_top.sv
tb/ramcfg_checker.sv
tb/ramcfg_tb.sv

// File: hdl/delay_pipe.sv
////////////////////////////////////////////////////////////////////////////
// Fixed delay line of DEPTH register stages, WIDTH bits wide
// DEPTH must be 1 or more
// All stages clear to zero on synchronous reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module delay_pipe
#(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
)
(
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    logic [WIDTH-1:0] stage [DEPTH];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
                stage[i] <= '0;
        end
        else
        begin
            stage[0] <= d;
            // Shift toward the output end
            for (int i = 1; i < DEPTH; i++)
                stage[i] <= stage[i-1];
        end
    end

    assign q = stage[DEPTH-1];

endmodule

// File: hdl/ramcfg_access.sv
////////////////////////////////////////////////////////////////////////////
// Engine and CPU access to the configuration table RAM
// Engine reads have priority; a CPU read waits for an engine gap or an
// engine read of upa. The CPU must hold upen, upa and updi stable from
// its strobe until uprdy, with one access outstanding at a time
// A write and a read of the same address in one cycle return updi on
// eng_rdd MEM_RD_LAT cycles later instead of the RAM data
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ramcfg_access
    import ramcfg_pkg::*;
#(
    parameter int ADDR_BITS  = ADDR_BITS_DFLT,
    parameter int DATA_WIDTH = DATA_WIDTH_DFLT,
    parameter int PARITY_EN  = 1
)
(
    input  logic                            clk,
    input  logic                            rst,

    // Engine read port
    input  logic                            eng_re,
    input  logic [ADDR_BITS-1:0]            eng_ra,
    input  logic                            active,
    output logic [DATA_WIDTH-1:0]           eng_rdd,

    // CPU port
    input  logic                            upen,
    input  logic [ADDR_BITS-1:0]            upa,
    input  logic                            upws,
    input  logic                            uprs,
    input  logic [DATA_WIDTH-1:0]           updi,
    output logic [DATA_WIDTH-1:0]           updo,
    output logic                            uprdy,

    // Parity configuration and error pulse
    input  logic                            par_force_err,
    input  logic                            par_err_dis,
    output logic                            par_err,

    // RAM port
    output logic                            memwe,
    output logic                            memre,
    output logic [ADDR_BITS-1:0]            memwa,
    output logic [DATA_WIDTH+PARITY_EN-1:0] memwrd,
    output logic [ADDR_BITS-1:0]            memra,
    input  logic [DATA_WIDTH+PARITY_EN-1:0] memrdd
);

    logic                  eng_rd;
    logic                  up_wr;
    logic                  up_rd;
    logic                  up_wr_ok;
    logic                  up_rd_ok;
    logic                  up_rd_lat;
    logic                  rd_req;
    logic [ADDR_BITS-1:0]  rd_addr;
    logic                  wr_conflict;
    logic                  bypass_d;
    logic [DATA_WIDTH-1:0] rdd_q;

    //////////////////////////////////////////////////////////////////////////
    // Request qualification
    //////////////////////////////////////////////////////////////////////////

    assign eng_rd = eng_re & active;
    assign up_wr  = upws & upen;
    assign up_rd  = uprs & upen;

    // Write reaches the RAM two cycles after the strobe
    delay_pipe #(
        .WIDTH (1),
        .DEPTH (WR_ISSUE_LAT)
    ) u_wr_issue (
        .clk (clk),
        .rst (rst),
        .d   (up_wr),
        .q   (up_wr_ok)
    );

    // Grant on engine gap, or ride along on an engine read of upa
    assign up_rd_ok = up_rd_lat & (~eng_rd | (eng_ra == upa));

    always_ff @(posedge clk)
    begin
        if (rst)
            up_rd_lat <= 1'b0;
        else if (!upen)
            up_rd_lat <= 1'b0;
        else if (up_rd_ok)
            up_rd_lat <= 1'b0;
        else if (up_rd)
            up_rd_lat <= 1'b1;
    end

    //////////////////////////////////////////////////////////////////////////
    // RAM access and collision bypass
    //////////////////////////////////////////////////////////////////////////

    assign memwe = up_wr_ok;
    assign memwa = upa;

    assign rd_req  = eng_rd | up_rd_ok;
    assign rd_addr = eng_rd ? eng_ra : upa;

    // Write to the address being read this cycle
    assign wr_conflict = memwe & (memwa == rd_addr);

    assign memre = rd_req & ~wr_conflict;
    assign memra = rd_addr;

    // Marks which returning read takes updi instead of RAM data
    delay_pipe #(
        .WIDTH (1),
        .DEPTH (MEM_RD_LAT)
    ) u_bypass_line (
        .clk (clk),
        .rst (rst),
        .d   (rd_req & wr_conflict),
        .q   (bypass_d)
    );

    assign eng_rdd = bypass_d ? updi : memrdd[DATA_WIDTH-1:0];

    //////////////////////////////////////////////////////////////////////////
    // CPU completion
    //////////////////////////////////////////////////////////////////////////

    delay_pipe #(
        .WIDTH (1),
        .DEPTH (CPU_DONE_LAT)
    ) u_done_line (
        .clk (clk),
        .rst (rst),
        .d   (up_rd_ok | up_wr_ok),
        .q   (uprdy)
    );

    // Read data one cycle after eng_rdd, lines up with uprdy
    delay_pipe #(
        .WIDTH (DATA_WIDTH),
        .DEPTH (1)
    ) u_updo_reg (
        .clk (clk),
        .rst (rst),
        .d   (eng_rdd),
        .q   (rdd_q)
    );

    assign updo = upen ? rdd_q : '0;

    //////////////////////////////////////////////////////////////////////////
    // Parity generation and check
    //////////////////////////////////////////////////////////////////////////

    generate
        if (PARITY_EN != 0)
        begin : g_parity
            logic wr_par;
            logic re_d;
            logic par_bit_q;
            logic par_err_nxt;

            // Even parity over data and bit, optionally corrupted
            assign wr_par = (^updi) ^ par_force_err;
            assign memwrd = {wr_par, updi};

            // RAM read enable aligned with rdd_q
            delay_pipe #(
                .WIDTH (1),
                .DEPTH (MEM_RD_LAT + 1)
            ) u_re_line (
                .clk (clk),
                .rst (rst),
                .d   (memre),
                .q   (re_d)
            );

            delay_pipe #(
                .WIDTH (1),
                .DEPTH (1)
            ) u_par_bit (
                .clk (clk),
                .rst (rst),
                .d   (memrdd[DATA_WIDTH]),
                .q   (par_bit_q)
            );

            // Bypassed reads never set re_d, so only real RAM data is checked
            assign par_err_nxt = ~par_err_dis & re_d & (^{par_bit_q, rdd_q});

            delay_pipe #(
                .WIDTH (1),
                .DEPTH (1)
            ) u_par_err (
                .clk (clk),
                .rst (rst),
                .d   (par_err_nxt),
                .q   (par_err)
            );
        end
        else
        begin : g_no_parity
            assign memwrd  = updi;
            assign par_err = 1'b0;
        end
    endgenerate

endmodule

// File: hdl/ramcfg_alarm.sv
////////////////////////////////////////////////////////////////////////////
// Parity alarm collector
// par_alarm is sticky until alarm_clr; err_count counts par_err pulses
// and stops at all ones. alarm_clr wins over an error in the same cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ramcfg_alarm
    import ramcfg_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    par_err,
    input  logic                    alarm_clr,
    output logic                    par_alarm,
    output logic [ERR_CNT_BITS-1:0] err_count
);

    localparam logic [ERR_CNT_BITS-1:0] CNT_MAX = '1;

    logic cnt_sat;

    assign cnt_sat = (err_count == CNT_MAX);

    // Sticky flag
    always_ff @(posedge clk)
    begin
        if (rst)
            par_alarm <= 1'b0;
        else if (alarm_clr)
            par_alarm <= 1'b0;
        else if (par_err)
            par_alarm <= 1'b1;
    end

    // Saturating event counter
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            err_count <= '0;
        end
        else if (alarm_clr)
        begin
            err_count <= '0;
        end
        else if (par_err && !cnt_sat)
        begin
            err_count <= err_count + 1'b1;
        end
    end

endmodule

// File: hdl/ramcfg_mem.sv
////////////////////////////////////////////////////////////////////////////
// Table RAM model, one write port and one read port
// Read data appears MEM_RD_LAT cycles after memre and holds until the
// next read; a read and a write of the same address in one cycle must
// not happen, the access block suppresses such reads
// Contents are undefined after power up
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ramcfg_mem
    import ramcfg_pkg::*;
#(
    parameter int ADDR_BITS  = ADDR_BITS_DFLT,
    parameter int DATA_WIDTH = DATA_WIDTH_DFLT,
    parameter int PARITY_EN  = 1
)
(
    input  logic                            clk,
    input  logic                            memwe,
    input  logic [ADDR_BITS-1:0]            memwa,
    input  logic [DATA_WIDTH+PARITY_EN-1:0] memwrd,
    input  logic                            memre,
    input  logic [ADDR_BITS-1:0]            memra,
    output logic [DATA_WIDTH+PARITY_EN-1:0] memrdd
);

    localparam int MEM_WIDTH = DATA_WIDTH + PARITY_EN;
    localparam int NUM_WORDS = 1 << ADDR_BITS;

    logic [MEM_WIDTH-1:0] mem_array [NUM_WORDS];
    logic [MEM_WIDTH-1:0] rd_word;

    // Write port
    always_ff @(posedge clk)
    begin
        if (memwe)
            mem_array[memwa] <= memwrd;
    end

    // Array read, first latency stage
    always_ff @(posedge clk)
    begin
        if (memre)
            rd_word <= mem_array[memra];
    end

    // Remaining output stages
    delay_pipe #(
        .WIDTH (MEM_WIDTH),
        .DEPTH (MEM_RD_LAT - 1)
    ) u_rd_pipe (
        .clk (clk),
        .rst (1'b0),
        .d   (rd_word),
        .q   (memrdd)
    );

endmodule

// File: hdl/ramcfg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared sizes and fixed latencies of the configuration table subsystem
// The latencies are tied to the pipeline structure of ramcfg_access and
// ramcfg_mem and are not meant to be changed on their own
////////////////////////////////////////////////////////////////////////////

package ramcfg_pkg;

    // Default table geometry, 32 words of 32 bits
    localparam int ADDR_BITS_DFLT  = 5;
    localparam int DATA_WIDTH_DFLT = 32;

    //////////////////////////////////////////////////////////////////////////
    // Fixed pipeline latencies, in clock cycles
    //////////////////////////////////////////////////////////////////////////

    // RAM read, memre to valid memrdd
    localparam int MEM_RD_LAT   = 4;

    // CPU write strobe to RAM write enable
    localparam int WR_ISSUE_LAT = 2;

    // Granted CPU access to uprdy
    localparam int CPU_DONE_LAT = 5;

    // Parity error event counter width
    localparam int ERR_CNT_BITS = 8;

endpackage

// File: hdl/ramcfg_top.sv
////////////////////////////////////////////////////////////////////////////
// Configuration table subsystem top level
// Engine read data is valid MEM_RD_LAT cycles after eng_re with active
// CPU accesses end with a one-cycle uprdy pulse
// PARITY_EN adds one parity bit per RAM word and enables the alarm path
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ramcfg_top
    import ramcfg_pkg::*;
#(
    parameter int ADDR_BITS  = ADDR_BITS_DFLT,
    parameter int DATA_WIDTH = DATA_WIDTH_DFLT,
    parameter int PARITY_EN  = 1
)
(
    input  logic                    clk,
    input  logic                    rst,

    // Engine
    input  logic                    eng_re,
    input  logic [ADDR_BITS-1:0]    eng_ra,
    input  logic                    active,
    output logic [DATA_WIDTH-1:0]   eng_rdd,

    // CPU
    input  logic                    upen,
    input  logic [ADDR_BITS-1:0]    upa,
    input  logic                    upws,
    input  logic                    uprs,
    input  logic [DATA_WIDTH-1:0]   updi,
    output logic [DATA_WIDTH-1:0]   updo,
    output logic                    uprdy,

    // Static configuration
    input  logic                    par_force_err,
    input  logic                    par_err_dis,

    // Alarm
    input  logic                    alarm_clr,
    output logic                    par_alarm,
    output logic [ERR_CNT_BITS-1:0] err_count
);

    localparam int MEM_WIDTH = DATA_WIDTH + PARITY_EN;

    logic                 memwe;
    logic                 memre;
    logic [ADDR_BITS-1:0] memwa;
    logic [ADDR_BITS-1:0] memra;
    logic [MEM_WIDTH-1:0] memwrd;
    logic [MEM_WIDTH-1:0] memrdd;
    logic                 par_err;

    ramcfg_access #(
        .ADDR_BITS  (ADDR_BITS),
        .DATA_WIDTH (DATA_WIDTH),
        .PARITY_EN  (PARITY_EN)
    ) u_access (
        .clk           (clk),
        .rst           (rst),
        .eng_re        (eng_re),
        .eng_ra        (eng_ra),
        .active        (active),
        .eng_rdd       (eng_rdd),
        .upen          (upen),
        .upa           (upa),
        .upws          (upws),
        .uprs          (uprs),
        .updi          (updi),
        .updo          (updo),
        .uprdy         (uprdy),
        .par_force_err (par_force_err),
        .par_err_dis   (par_err_dis),
        .par_err       (par_err),
        .memwe         (memwe),
        .memre         (memre),
        .memwa         (memwa),
        .memwrd        (memwrd),
        .memra         (memra),
        .memrdd        (memrdd)
    );

    ramcfg_mem #(
        .ADDR_BITS  (ADDR_BITS),
        .DATA_WIDTH (DATA_WIDTH),
        .PARITY_EN  (PARITY_EN)
    ) u_mem (
        .clk    (clk),
        .memwe  (memwe),
        .memwa  (memwa),
        .memwrd (memwrd),
        .memre  (memre),
        .memra  (memra),
        .memrdd (memrdd)
    );

    ramcfg_alarm u_alarm (
        .clk       (clk),
        .rst       (rst),
        .par_err   (par_err),
        .alarm_clr (alarm_clr),
        .par_alarm (par_alarm),
        .err_count (err_count)
    );

endmodule

// File: tb/ramcfg_checker.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on the access block, bound into ramcfg_access
// Assumes the CPU holds upen stable from its strobe until uprdy
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ramcfg_checker
    import ramcfg_pkg::*;
#(
    parameter int ADDR_BITS = ADDR_BITS_DFLT
)
(
    input logic                 clk,
    input logic                 rst,
    input logic                 upen,
    input logic                 upws,
    input logic                 uprdy,
    input logic                 memwe,
    input logic                 memre,
    input logic [ADDR_BITS-1:0] memwa,
    input logic [ADDR_BITS-1:0] memra
);

    // No RAM read of the word being written
    a_no_rw_collision: assert property (@(posedge clk) disable iff (rst)
        !(memre && memwe && (memwa == memra)))
        else $error("memre and memwe active on the same address");

    // Completion is a single-cycle pulse
    a_uprdy_pulse: assert property (@(posedge clk) disable iff (rst)
        uprdy |=> !uprdy)
        else $error("uprdy high for more than one cycle");

    // Write issue follows the strobe by a fixed delay, both ways
    a_wr_issue: assert property (@(posedge clk) disable iff (rst)
        (upws && upen) |-> ##WR_ISSUE_LAT memwe)
        else $error("memwe missing after CPU write strobe");

    a_wr_origin: assert property (@(posedge clk) disable iff (rst)
        memwe |-> $past(upws && upen, WR_ISSUE_LAT))
        else $error("memwe without a matching CPU write strobe");

endmodule

// File: tb/ramcfg_tb.sv
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the configuration table subsystem
// Runs with the default geometry of 32 words of 32 bits and parity on
// Stops at the first mismatch or when the cycle limit is reached
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ramcfg_tb;
    import ramcfg_pkg::*;

    localparam int ADDR_BITS   = ADDR_BITS_DFLT;
    localparam int DATA_WIDTH  = DATA_WIDTH_DFLT;
    localparam int NUM_WORDS   = 1 << ADDR_BITS;
    localparam int CYCLE_LIMIT = 4000;

    logic                    clk;
    logic                    rst;
    logic                    eng_re;
    logic [ADDR_BITS-1:0]    eng_ra;
    logic                    active;
    logic [DATA_WIDTH-1:0]   eng_rdd;
    logic                    upen;
    logic [ADDR_BITS-1:0]    upa;
    logic                    upws;
    logic                    uprs;
    logic [DATA_WIDTH-1:0]   updi;
    logic [DATA_WIDTH-1:0]   updo;
    logic                    uprdy;
    logic                    par_force_err;
    logic                    par_err_dis;
    logic                    alarm_clr;
    logic                    par_alarm;
    logic [ERR_CNT_BITS-1:0] err_count;

    // Reference table and forced-parity flags
    logic [DATA_WIDTH-1:0] model [NUM_WORDS];
    logic                  bad   [NUM_WORDS];

    int seed   = 32'h60f3f8fe;
    int cycles = 0;
    int errors = 0;

    ramcfg_top #(
        .ADDR_BITS  (ADDR_BITS),
        .DATA_WIDTH (DATA_WIDTH),
        .PARITY_EN  (1)
    ) u_dut (
        .clk (clk), .rst (rst),
        .eng_re (eng_re), .eng_ra (eng_ra), .active (active), .eng_rdd (eng_rdd),
        .upen (upen), .upa (upa), .upws (upws), .uprs (uprs), .updi (updi),
        .updo (updo), .uprdy (uprdy),
        .par_force_err (par_force_err), .par_err_dis (par_err_dis),
        .alarm_clr (alarm_clr), .par_alarm (par_alarm), .err_count (err_count)
    );

    bind ramcfg_access ramcfg_checker #(.ADDR_BITS (ADDR_BITS)) u_checker (
        .clk (clk), .rst (rst), .upen (upen), .upws (upws), .uprdy (uprdy),
        .memwe (memwe), .memre (memre), .memwa (memwa), .memra (memra)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: simulation ran past %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %s exp %h got %h", name, exp, got);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // Counts falling edges until uprdy is seen
    task automatic wait_uprdy(output int lat);
        lat = 0;
        do
        begin
            @(negedge clk);
            lat++;
        end
        while (!uprdy);
    endtask

    task automatic cpu_write(input logic [ADDR_BITS-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data, input logic force_err);
        int lat;
        @(posedge clk);
        upa           <= addr;
        updi          <= data;
        par_force_err <= force_err;
        upws          <= 1'b1;
        @(posedge clk);
        upws <= 1'b0;
        wait_uprdy(lat);
        check("uprdy_wr_lat", WR_ISSUE_LAT + CPU_DONE_LAT, lat);
        model[addr] = data;
        bad[addr]   = force_err;
    endtask

    task automatic cpu_read_expect(input logic [ADDR_BITS-1:0] addr);
        int lat;
        @(posedge clk);
        upa  <= addr;
        uprs <= 1'b1;
        @(posedge clk);
        uprs <= 1'b0;
        wait_uprdy(lat);
        // Latch cycle plus completion delay with the engine idle
        check("uprdy_rd_lat", 1 + CPU_DONE_LAT, lat);
        check("updo", model[addr], updo);
    endtask

    task automatic engine_read_expect(input int n);
        logic [DATA_WIDTH-1:0] exp_q [$];
        logic [ADDR_BITS-1:0]  addr;
        for (int i = 0; i < n + MEM_RD_LAT; i++)
        begin
            @(posedge clk);
            if (i < n)
            begin
                addr = ADDR_BITS'($random(seed));
                eng_re <= 1'b1;
                eng_ra <= addr;
                exp_q.push_back(model[addr]);
            end
            else
            begin
                eng_re <= 1'b0;
            end
            @(negedge clk);
            if (i >= MEM_RD_LAT)
                check("eng_rdd", exp_q.pop_front(), eng_rdd);
        end
    endtask

    // An inactive read must not disturb the returned data
    task automatic engine_inactive_read();
        logic [ADDR_BITS-1:0] prev;
        // Previous word must differ from word 3 so a stray read shows up
        prev = (model[5'd4] !== model[5'd3]) ? 5'd4 : 5'd5;
        @(posedge clk);
        eng_re <= 1'b1;
        eng_ra <= prev;
        @(posedge clk);
        active <= 1'b0;
        eng_ra <= 5'd3;
        @(posedge clk);
        eng_re <= 1'b0;
        active <= 1'b1;
        repeat (MEM_RD_LAT) @(negedge clk);
        check("eng_rdd_held", model[prev], eng_rdd);
        engine_read_expect(4);
    endtask

    task automatic collision_bypass(input logic [ADDR_BITS-1:0] addr);
        logic [DATA_WIDTH-1:0] data;
        int                    lat;
        data = $random(seed);
        @(posedge clk);
        upa           <= addr;
        updi          <= data;
        par_force_err <= 1'b0;
        upws          <= 1'b1;
        @(posedge clk);
        upws <= 1'b0;
        // Engine read lands on the memwe cycle
        @(posedge clk);
        eng_re <= 1'b1;
        eng_ra <= addr;
        @(posedge clk);
        eng_re <= 1'b0;
        repeat (MEM_RD_LAT) @(negedge clk);
        check("eng_rdd_bypass", data, eng_rdd);
        wait_uprdy(lat);
        model[addr] = data;
        bad[addr]   = 1'b0;
    endtask

    task automatic read_under_load(input logic [ADDR_BITS-1:0] addr, input logic by_same);
        int lat;
        @(posedge clk);
        upa    <= addr;
        uprs   <= 1'b1;
        eng_re <= 1'b1;
        eng_ra <= addr ^ 5'd1;
        repeat (20)
        begin
            @(posedge clk);
            uprs <= 1'b0;
            @(negedge clk);
            check("uprdy_held", 0, 32'(uprdy));
        end
        // Release by a gap or by a read of upa
        @(posedge clk);
        if (by_same)
            eng_ra <= addr;
        else
            eng_re <= 1'b0;
        @(posedge clk);
        eng_re <= 1'b0;
        wait_uprdy(lat);
        check("uprdy_release_lat", CPU_DONE_LAT, lat);
        check("updo", model[addr], updo);
    endtask

    task automatic read_check_alarm(input logic [ADDR_BITS-1:0] addr, input logic dis,
                                    input int exp_cnt);
        @(posedge clk);
        par_err_dis <= dis;
        cpu_read_expect(addr);
        repeat (3) @(negedge clk);
        check("par_alarm", 32'(bad[addr] & ~dis), 32'(par_alarm));
        check("err_count", exp_cnt, 32'(err_count));
        @(posedge clk);
        par_err_dis <= 1'b0;
    endtask

    task automatic parity_alarm();
        read_check_alarm(5'd7, 1'b0, 0);
        cpu_write(5'd7, $random(seed), 1'b1);
        read_check_alarm(5'd7, 1'b0, 1);
        @(posedge clk);
        alarm_clr <= 1'b1;
        @(posedge clk);
        alarm_clr <= 1'b0;
        @(negedge clk);
        check("par_alarm_clr", 0, 32'(par_alarm));
        check("err_count_clr", 0, 32'(err_count));
        read_check_alarm(5'd7, 1'b1, 0);
        cpu_write(5'd7, $random(seed), 1'b0);
        read_check_alarm(5'd7, 1'b0, 0);
    endtask

    task automatic reset_and_upen();
        @(negedge clk);
        check("uprdy_rst", 0, 32'(uprdy));
        check("par_alarm_rst", 0, 32'(par_alarm));
        check("err_count_rst", 0, 32'(err_count));
        @(posedge clk);
        upws <= 1'b1;
        uprs <= 1'b1;
        @(posedge clk);
        upws <= 1'b0;
        uprs <= 1'b0;
        repeat (10)
        begin
            @(negedge clk);
            check("uprdy_upen_low", 0, 32'(uprdy));
            check("updo_upen_low", 0, updo);
        end
        @(posedge clk);
        upen <= 1'b1;
    endtask

    initial
    begin
        rst           = 1'b1;
        eng_re        = 1'b0;
        eng_ra        = '0;
        active        = 1'b1;
        upen          = 1'b0;
        upa           = '0;
        upws          = 1'b0;
        uprs          = 1'b0;
        updi          = '0;
        par_force_err = 1'b0;
        par_err_dis   = 1'b0;
        alarm_clr     = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        reset_and_upen();
        for (int a = 0; a < NUM_WORDS; a++)
            cpu_write(ADDR_BITS'(a), $random(seed), 1'b0);
        for (int a = 0; a < NUM_WORDS; a++)
            cpu_read_expect(ADDR_BITS'(a));
        engine_read_expect(16);
        engine_inactive_read();
        collision_bypass(5'd12);
        engine_read_expect(8);
        read_under_load(5'd20, 1'b0);
        read_under_load(5'd21, 1'b1);
        parity_alarm();

        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
